//--- test/ramio_cases.txt
# name op type address data expected, numbers in hex
# op W store, R load, U uart byte; type b h w (loads also bu hu); expected unused for W
w_word0    W w  00000010 12345678 00000000
r_word0    R w  00000010 00000000 12345678
r_fresh    R w  00000020 00000000 00000000
w_byte80   W b  00000030 00000080 00000000
r_byte_s   R b  00000030 00000000 ffffff80
r_byte_u   R bu 00000030 00000000 00000080
w_word1    W w  00000040 a1b2c3d4 00000000
w_lane2    W b  00000042 0000005a 00000000
r_lane_w   R w  00000040 00000000 a15ac3d4
r_half_s   R h  00000042 00000000 ffffa15a
r_half_u   R hu 00000042 00000000 0000a15a
r_byte_hi  R bu 00000043 00000000 000000a1
w_upper    W w  00000044 cafef00d 00000000
r_upper    R w  00000044 00000000 cafef00d
w_half     W h  00000026 0000beef 00000000
r_half_w   R w  00000024 00000000 beef0000
w_conf_a   W w  00000018 11112222 00000000
w_conf_b   W w  00000098 33334444 00000000
r_conf_a   R w  00000018 00000000 11112222
r_conf_b   R w  00000098 00000000 33334444
u_tx_a5    U b  ffffffff 000000a5 000000a5
u_tx_low   U b  ffffffff 0000013c 0000003c
r_keep     R w  00000010 00000000 12345678

//--- build.f
+incdir+logic
logic/ramio_pkg.sv
logic/ramio_request.sv
logic/line_cache.sv
logic/burst_ram.sv
logic/uart_tx.sv
logic/ramio_top.sv
test/ramio_props.sv
test/ramio_checker.sv
test/ramio_tb.sv

//--- Bender.yml
package:
  name: ramio

sources:
  - include_dirs:
      - logic
    files:
      - logic/ramio_pkg.sv
      - logic/ramio_request.sv
      - logic/line_cache.sv
      - logic/burst_ram.sv
      - logic/uart_tx.sv
      - logic/ramio_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/ramio_props.sv
      - test/ramio_checker.sv
      - test/ramio_tb.sv

//--- test/ramio_tb.sv
`timescale 1ns/100ps

`include "ramio_defines.svh"

module ramio_tb
  import ramio_pkg::*;
();

  localparam int    PERIOD       = 100;
  localparam int    RESET_CYCLES = 5;
  localparam int    MAX_GAP      = 3;   // idle cycles between accesses
  // worst access is a uart byte, misses are far shorter
  localparam int    ACCESS_LIMIT = 10 * `CLKS_PER_BIT + 2 * `BURST_READ_LATENCY + 12;
  localparam string CASE_FILE    = "test/ramio_cases.txt";

  logic        clk;
  logic        rst_n;
  logic        enable;
  write_type_e write_type;
  read_type_e  read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic        uart_tx;

  string       c_name[$];
  string       c_op[$];
  string       c_type[$];
  logic [31:0] c_addr[$];
  logic [31:0] c_data[$];
  logic [31:0] c_exp[$];
  int          num_cases   = 0;
  logic        cases_ready = 1'b0;
  logic        hung        = 1'b0;

  ramio_top UUT (
    .clk(clk), .rst_n(rst_n),
    .enable(enable), .write_type(write_type), .read_type(read_type),
    .address(address), .data_in(data_in),
    .data_out(data_out), .data_out_ready(data_out_ready),
    .busy(busy), .uart_tx(uart_tx)
  );

  ramio_checker chk (
    .clk(clk), .rst_n(rst_n), .busy(busy),
    .data_out(data_out), .data_out_ready(data_out_ready), .uart_tx(uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic write_type_e write_kind(input string t);
    case (t)
      "b":     return WT_BYTE;
      "h":     return WT_HALF;
      "w":     return WT_WORD;
      default: return WT_NONE;
    endcase
  endfunction

  function automatic read_type_e read_kind(input string t);
    case (t)
      "b":     return RT_BYTE;
      "h":     return RT_HALF;
      "w":     return RT_WORD;
      "bu":    return RT_BYTE_U;
      "hu":    return RT_HALF_U;
      default: return RT_NONE;
    endcase
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    string       ty;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open case file %s", CASE_FILE);
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line[0] == "#") continue;  // column notes
      n = $sscanf(line, "%s %s %s %h %h %h", name, op, ty, a, d, e);
      if (n == 6) begin
        c_name.push_back(name);
        c_op.push_back(op);
        c_type.push_back(ty);
        c_addr.push_back(a);
        c_data.push_back(d);
        c_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------------------
  // one access, entered and left on a falling edge
  // ------------------------------------------------------------
  task automatic run_access(input int i);
    write_type_e wt;
    read_type_e  rt;
    int          waited;
    wt = WT_NONE;
    rt = RT_NONE;
    if (c_op[i] == "R") rt = read_kind(c_type[i]);
    else wt = write_kind(c_type[i]);
    if (wt == WT_NONE && rt == RT_NONE) begin
      chk.report_problem(c_name[i], "unknown access type in case file");
      return;
    end
    chk.begin_test(c_name[i], rt, c_op[i] == "U", c_exp[i]);
    enable     = 1'b1;
    write_type = wt;
    read_type  = rt;
    address    = c_addr[i];
    data_in    = c_data[i];
    @(negedge clk);
    enable     = 1'b0;
    write_type = WT_NONE;
    read_type  = RT_NONE;
    if (!busy) begin
      chk.report_problem(c_name[i], "busy did not rise after enable");
      return;
    end
    waited = 0;
    while (busy && waited < ACCESS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      chk.report_problem(c_name[i], "busy never fell, access hung");
      hung = 1'b1;
    end else begin
      @(negedge clk);  // ready pulse already captured
      chk.end_test();
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    enable     = 1'b0;
    write_type = WT_NONE;
    read_type  = RT_NONE;
    address    = 32'h0;
    data_in    = 32'h0;
    void'($urandom(94097));
    load_cases();
    num_cases   = c_name.size();
    cases_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    chk.check_idle("reset_state");
    for (int i = 0; i < num_cases && !hung; i++) begin
      repeat ($urandom % (MAX_GAP + 1)) @(negedge clk);
      run_access(i);
    end
    if (num_cases == 0) $display("no cases were read from %s", CASE_FILE);
    $display("tests run %0d, passed %0d, failed %0d, other errors %0d",
             chk.pass_count + chk.fail_count, chk.pass_count, chk.fail_count,
             chk.error_count + UUT.props.assert_fails);
    if (num_cases > 0 && chk.fail_count == 0 && chk.error_count == 0 &&
        UUT.props.assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // budget scales with the number of cases
  initial begin : watchdog
    wait (cases_ready);
    #((num_cases + 1) * (ACCESS_LIMIT + MAX_GAP + 2) * 2 * PERIOD
      + (RESET_CYCLES + 2) * PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- test/ramio_checker.sv
`timescale 1ns/100ps

`include "ramio_defines.svh"

module ramio_checker
  import ramio_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        busy,
  input logic [31:0] data_out,
  input logic        data_out_ready,
  input logic        uart_tx
);

  localparam int HALF_BIT = `CLKS_PER_BIT / 2 - 1;  // negedges from first low to bit centre

  int pass_count  = 0;
  int fail_count  = 0;
  int error_count = 0;  // problems seen outside a test

  string       test_name;
  logic        armed = 1'b0;
  logic        want_ready;
  logic        want_uart;
  logic [31:0] expected;
  logic        got_ready;
  logic [31:0] got_data;
  int          rx_frames = 0;
  int          rx_mark;
  logic [7:0]  rx_byte;

  task automatic begin_test(input string name, input read_type_e rt, input logic is_uart,
                            input logic [31:0] exp);
    test_name  = name;
    want_ready = (rt != RT_NONE);
    want_uart  = is_uart;
    expected   = exp;
    got_ready  = 1'b0;
    rx_mark    = rx_frames;
    armed      = 1'b1;
  endtask

  task automatic end_test();
    logic        ok;
    logic [31:0] actual;
    ok     = 1'b1;
    actual = 'x;
    armed  = 1'b0;
    if (want_ready && !got_ready) begin
      $display("test %s: read finished without a data_out_ready pulse", test_name);
      ok = 1'b0;
    end else if (!want_ready && got_ready) begin
      $display("test %s: data_out_ready pulsed for a write", test_name);
      ok = 1'b0;
    end else if (want_uart && rx_frames == rx_mark) begin
      $display("test %s: no framed byte was seen on uart_tx", test_name);
      ok = 1'b0;
    end else if (want_ready || want_uart) begin
      actual = want_ready ? got_data : {24'h0, rx_byte};
      if (actual !== expected) begin
        $display("Fail %s expected %08h actual %08h", test_name, expected, actual);
        ok = 1'b0;
      end
    end
    if (ok) begin
      pass_count++;
      $display("Pass %s", test_name);
    end else begin
      fail_count++;
    end
  endtask

  task automatic check_idle(input string name);
    if (busy !== 1'b0 || data_out_ready !== 1'b0 || uart_tx !== 1'b1) begin
      $display("test %s: after reset busy=%b data_out_ready=%b uart_tx=%b, wanted 0 0 1",
               name, busy, data_out_ready, uart_tx);
      fail_count++;
    end else begin
      pass_count++;
      $display("Pass %s", name);
    end
  endtask

  task automatic report_problem(input string name, input string what);
    $display("test %s: %s", name, what);
    armed = 1'b0;
    fail_count++;
  endtask

  // ------------------------------------------------------------
  // read data capture, mid cycle
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n === 1'b1 && data_out_ready === 1'b1) begin
      if (armed) begin
        got_ready = 1'b1;
        got_data  = data_out;
      end else begin
        $display("data_out_ready pulsed with no access in flight");
        error_count++;
      end
    end
  end

  // ------------------------------------------------------------
  // 8N1 receiver, samples at bit centres
  // ------------------------------------------------------------
  initial begin : uart_receiver
    logic [7:0] bits;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat (HALF_BIT) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          $display("uart_tx start bit did not hold low to its centre");
          error_count++;
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge clk);
            bits[i] = uart_tx;  // LSB first
          end
          repeat (`CLKS_PER_BIT) @(negedge clk);
          if (uart_tx !== 1'b1) begin
            $display("uart_tx stop bit was not high");
            error_count++;
          end else begin
            // last negedge inside the stop bit
            repeat (`CLKS_PER_BIT - HALF_BIT - 1) @(negedge clk);
            if (busy !== 1'b1) begin
              $display("busy fell before the uart stop bit ended");
              error_count++;
            end else begin
              rx_byte = bits;
              rx_frames++;
            end
          end
        end
      end
    end
  end

endmodule

//--- test/ramio_props.sv
`timescale 1ns/100ps

module ramio_props (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input logic busy,
  input logic data_out_ready,
  input logic br_cmd_en,
  input logic br_cmd,            // 0 read, 1 write
  input logic br_rd_data_valid,
  input logic uart_tx
);

  int   assert_fails = 0;  // failed assertion count
  logic read_pending;      // read command out, data not back yet

  always_ff @(posedge clk) begin
    if (!rst_n) read_pending <= 1'b0;
    else if (br_rd_data_valid) read_pending <= 1'b0;
    else if (br_cmd_en && !br_cmd) read_pending <= 1'b1;
  end

  ready_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> $past(busy))
    else begin
      assert_fails++;
      $error("data_out_ready without busy in the cycle before");
    end

  no_enable_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(enable && busy))
    else begin
      assert_fails++;
      $error("enable asserted while busy");
    end

  no_cmd_during_read: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> !read_pending)
    else begin
      assert_fails++;
      $error("burst command issued while a read is pending");
    end

  idle_line_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> uart_tx)
    else begin
      assert_fails++;
      $error("uart_tx not idle high after reset");
    end

endmodule

bind ramio_top ramio_props props (
  .clk(clk),
  .rst_n(rst_n),
  .enable(enable),
  .busy(busy),
  .data_out_ready(data_out_ready),
  .br_cmd_en(br_cmd_en),
  .br_cmd(br_cmd),
  .br_rd_data_valid(br_rd_data_valid),
  .uart_tx(uart_tx)
);

//--- logic/ramio_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "ramio_defines.svh"

module ramio_top
  import ramio_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  write_type_e write_type,
  input  read_type_e  read_type,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic        uart_tx
);

  localparam int IX_W  = `CACHE_LINE_IX_BITWIDTH;
  localparam int TAG_W = `RAM_ADDRESS_BITWIDTH - IX_W;

  // ----------------------------------------------------------
  // request stage to cache / uart
  // ----------------------------------------------------------
  logic              req_valid;
  write_type_e       req_write_type;
  read_type_e        req_read_type;
  logic [2:0]        req_offset;
  logic [IX_W-1:0]   req_index;
  logic [TAG_W-1:0]  req_tag;
  logic [31:0]       req_data;
  logic              cache_done;
  logic [31:0]       cache_rd_data;
  logic              tx_start;
  logic [7:0]        tx_byte;
  logic              tx_busy;

  // burst RAM wiring, prefix br_
  burst_cmd_e                       br_cmd;
  logic                             br_cmd_en;
  logic [`RAM_ADDRESS_BITWIDTH-1:0] br_addr;
  logic [63:0]                      br_wr_data;
  logic [7:0]                       br_data_mask;
  logic [63:0]                      br_rd_data;
  logic                             br_rd_data_valid;

  ramio_request request (
    .clk(clk), .rst_n(rst_n),
    .enable(enable), .write_type(write_type), .read_type(read_type),
    .address(address), .data_in(data_in),
    .cache_done(cache_done), .cache_rd_data(cache_rd_data), .tx_busy(tx_busy),
    .busy(busy), .data_out(data_out), .data_out_ready(data_out_ready),
    .req_valid(req_valid), .req_write_type(req_write_type),
    .req_read_type(req_read_type), .req_offset(req_offset),
    .req_index(req_index), .req_tag(req_tag), .req_data(req_data),
    .tx_start(tx_start), .tx_byte(tx_byte)
  );

  line_cache #(
    .CACHE_LINE_IX_BITWIDTH(IX_W)
  ) cache (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_write_type(req_write_type),
    .req_read_type(req_read_type), .req_offset(req_offset),
    .req_index(req_index), .req_tag(req_tag), .req_data(req_data),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid),
    .cache_done(cache_done), .cache_rd_data(cache_rd_data),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_data_mask(br_data_mask)
  );

  burst_ram br (
    .clk(clk), .rst_n(rst_n),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_data_mask(br_data_mask),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid)
  );

  uart_tx #(
    .CLKS_PER_BIT(`CLKS_PER_BIT)
  ) uart (
    .clk(clk), .rst_n(rst_n),
    .tx_start(tx_start), .tx_byte(tx_byte),
    .tx_busy(tx_busy), .uart_tx(uart_tx)
  );

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "ramio_defines.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       uart_tx
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [8:0]       shreg;    // data bits then stop

  // ----------------------------------------------------------
  // 8N1 framing, LSB first
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      uart_tx <= 1'b1;  // line idles high
      clk_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '1;
    end else if (!tx_busy) begin
      if (tx_start) begin
        shreg   <= {1'b1, tx_byte};
        uart_tx <= 1'b0;  // start bit
        tx_busy <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        tx_busy <= 1'b0;  // stop bit done
      end else begin
        uart_tx <= shreg[0];
        shreg   <= {1'b1, shreg[8:1]};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/burst_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "ramio_defines.svh"

module burst_ram
  import ramio_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  burst_cmd_e                       br_cmd,      // 0 read, 1 write
  input  logic                             br_cmd_en,
  input  logic [`RAM_ADDRESS_BITWIDTH-1:0] br_addr,
  input  logic [63:0]                      br_wr_data,
  input  logic [7:0]                       br_data_mask,  // 1 keeps the byte
  output logic [63:0]                      br_rd_data,
  output logic                             br_rd_data_valid
);

  localparam int DEPTH = 2 ** `RAM_ADDRESS_BITWIDTH;
  localparam int LAT   = `BURST_READ_LATENCY;

  logic [63:0]    mem     [DEPTH];
  logic [63:0]    rd_pipe [LAT];
  logic [LAT-1:0] vld_pipe;
  logic           rd_cmd;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 64'h0;
    end
  end

  assign rd_cmd = br_cmd_en && (br_cmd == BR_READ);

  // write lands in the command cycle
  always @(posedge clk) begin
    if (br_cmd_en && br_cmd == BR_WRITE) begin
      for (int b = 0; b < 8; b++) begin
        if (!br_data_mask[b]) mem[br_addr][b*8 +: 8] <= br_wr_data[b*8 +: 8];
      end
    end
  end

  // ----------------------------------------------------------
  // read delay line
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    rd_pipe[0] <= mem[br_addr];
    for (int i = 1; i < LAT; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) vld_pipe <= '0;
    else        vld_pipe <= LAT'({vld_pipe, rd_cmd});
  end

  assign br_rd_data       = rd_pipe[LAT-1];
  assign br_rd_data_valid = vld_pipe[LAT-1];

endmodule

`default_nettype wire

//--- logic/line_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "ramio_defines.svh"

module line_cache
  import ramio_pkg::*;
#(
  parameter int CACHE_LINE_IX_BITWIDTH = `CACHE_LINE_IX_BITWIDTH
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  req_valid,
  input  write_type_e                           req_write_type,
  input  read_type_e                            req_read_type,
  input  logic [2:0]                            req_offset,
  input  logic [CACHE_LINE_IX_BITWIDTH-1:0]     req_index,
  input  logic [`RAM_ADDRESS_BITWIDTH-CACHE_LINE_IX_BITWIDTH-1:0] req_tag,
  input  logic [31:0]                           req_data,
  input  logic [63:0]                           br_rd_data,
  input  logic                                  br_rd_data_valid,
  output logic                                  cache_done,
  output logic [31:0]                           cache_rd_data,
  output burst_cmd_e                            br_cmd,
  output logic                                  br_cmd_en,
  output logic [`RAM_ADDRESS_BITWIDTH-1:0]      br_addr,
  output logic [63:0]                           br_wr_data,
  output logic [7:0]                            br_data_mask
);

  localparam int TAG_W = `RAM_ADDRESS_BITWIDTH - CACHE_LINE_IX_BITWIDTH;
  localparam int LINES = 2 ** CACHE_LINE_IX_BITWIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ_CMD,  // write-back sent, read goes next
    S_REFILL
  } state_e;

  state_e state;

  // line storage
  logic [63:0]                       line_data [LINES];
  logic [TAG_W-1:0]                  tag_mem   [LINES];
  logic [LINES-1:0]                  valid_bits;
  logic [LINES-1:0]                  dirty_bits;

  // access held across a miss
  write_type_e                       lat_write_type;
  read_type_e                        lat_read_type;
  logic [2:0]                        lat_offset;
  logic [CACHE_LINE_IX_BITWIDTH-1:0] lat_index;
  logic [TAG_W-1:0]                  lat_tag;
  logic [31:0]                       lat_data;

  // access in work this cycle
  write_type_e                       cur_write_type;
  read_type_e                        cur_read_type;
  logic [2:0]                        cur_offset;
  logic [CACHE_LINE_IX_BITWIDTH-1:0] cur_index;
  logic [TAG_W-1:0]                  cur_tag;
  logic [31:0]                       cur_data;

  logic        hit, miss_now, issue_wb, issue_rd, done_now, is_write;
  logic [63:0] src_line, bit_mask, wr_shift, merged_line, rd_shift;
  logic [7:0]  lanes;

  function automatic logic [7:0] lane_mask(write_type_e wt, logic [2:0] off);
    case (wt)
      WT_BYTE: return 8'b0000_0001 << off;
      WT_HALF: return 8'b0000_0011 << off;
      WT_WORD: return 8'b0000_1111 << off;
      default: return 8'b0000_0000;
    endcase
  endfunction

  function automatic logic [31:0] extend_load(logic [31:0] raw, read_type_e rt);
    case (rt)
      RT_BYTE:   return {{24{raw[7]}}, raw[7:0]};
      RT_HALF:   return {{16{raw[15]}}, raw[15:0]};
      RT_BYTE_U: return {24'h0, raw[7:0]};
      RT_HALF_U: return {16'h0, raw[15:0]};
      default:   return raw;
    endcase
  endfunction

  // ----------------------------------------------------------
  // lookup and data path
  // ----------------------------------------------------------
  always_comb begin
    if (state == S_IDLE) begin
      cur_write_type = req_write_type;
      cur_read_type  = req_read_type;
      cur_offset     = req_offset;
      cur_index      = req_index;
      cur_tag        = req_tag;
      cur_data       = req_data;
    end else begin
      cur_write_type = lat_write_type;
      cur_read_type  = lat_read_type;
      cur_offset     = lat_offset;
      cur_index      = lat_index;
      cur_tag        = lat_tag;
      cur_data       = lat_data;
    end
  end

  assign hit      = valid_bits[cur_index] && (tag_mem[cur_index] == cur_tag);
  assign miss_now = (state == S_IDLE) && req_valid && !hit;
  assign issue_wb = miss_now && valid_bits[cur_index] && dirty_bits[cur_index];
  assign issue_rd = (miss_now && !issue_wb) || (state == S_READ_CMD);
  assign done_now = ((state == S_IDLE) && req_valid && hit) ||
                    ((state == S_REFILL) && br_rd_data_valid);
  assign is_write = (cur_write_type != WT_NONE);

  // refill data goes straight through, no extra cycle
  assign src_line = (state == S_REFILL) ? br_rd_data : line_data[cur_index];

  always_comb begin
    lanes = lane_mask(cur_write_type, cur_offset);
    for (int i = 0; i < 8; i++) begin
      bit_mask[i*8 +: 8] = {8{lanes[i]}};
    end
  end

  assign wr_shift    = {32'h0, cur_data} << {cur_offset, 3'b000};
  assign merged_line = (src_line & ~bit_mask) | (wr_shift & bit_mask);
  assign rd_shift    = src_line >> {cur_offset, 3'b000};

  assign br_data_mask = 8'h00;  // full line every time

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      cache_done <= 1'b0;
      br_cmd_en  <= 1'b0;
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      cache_done <= done_now;
      br_cmd_en  <= issue_wb || issue_rd;
      case (state)
        S_IDLE: begin
          if (issue_wb) state <= S_READ_CMD;
          else if (issue_rd) state <= S_REFILL;
        end
        S_READ_CMD: state <= S_REFILL;
        S_REFILL:   if (br_rd_data_valid) state <= S_IDLE;
        default:    state <= S_IDLE;
      endcase
      if (done_now) begin
        valid_bits[cur_index] <= 1'b1;
        // a fresh refill starts clean
        dirty_bits[cur_index] <= is_write || ((state == S_IDLE) && dirty_bits[cur_index]);
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_valid) begin
      lat_write_type <= req_write_type;
      lat_read_type  <= req_read_type;
      lat_offset     <= req_offset;
      lat_index      <= req_index;
      lat_tag        <= req_tag;
      lat_data       <= req_data;
    end
    if (issue_wb) begin
      br_cmd     <= BR_WRITE;
      br_addr    <= {tag_mem[cur_index], cur_index};  // victim line
      br_wr_data <= line_data[cur_index];
    end else if (issue_rd) begin
      br_cmd  <= BR_READ;
      br_addr <= {cur_tag, cur_index};
    end
    if (done_now) begin
      line_data[cur_index] <= merged_line;
      tag_mem[cur_index]   <= cur_tag;
      cache_rd_data        <= extend_load(rd_shift[31:0], cur_read_type);
    end
  end

endmodule

`default_nettype wire

//--- logic/ramio_request.sv
`timescale 1ns/100ps
`default_nettype none

`include "ramio_defines.svh"

module ramio_request
  import ramio_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   enable,
  input  write_type_e                            write_type,
  input  read_type_e                             read_type,
  input  logic [31:0]                            address,
  input  logic [31:0]                            data_in,
  input  logic                                   cache_done,
  input  logic [31:0]                            cache_rd_data,
  input  logic                                   tx_busy,
  output logic                                   busy,
  output logic [31:0]                            data_out,
  output logic                                   data_out_ready,
  output logic                                   req_valid,
  output write_type_e                            req_write_type,
  output read_type_e                             req_read_type,
  output logic [2:0]                             req_offset,
  output logic [`CACHE_LINE_IX_BITWIDTH-1:0]     req_index,
  output logic [`RAM_ADDRESS_BITWIDTH-`CACHE_LINE_IX_BITWIDTH-1:0] req_tag,
  output logic [31:0]                            req_data,
  output logic                                   tx_start,
  output logic [7:0]                             tx_byte
);

  localparam int IX_W  = `CACHE_LINE_IX_BITWIDTH;
  localparam int TAG_W = `RAM_ADDRESS_BITWIDTH - IX_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_CACHE,      // waiting for cache_done
    S_TX_LAUNCH,  // tx_start on the wire, tx_busy not yet up
    S_TX_WAIT
  } state_e;

  state_e state;
  logic   to_uart;

  // only stores hit the transmitter, loads fall through to the cache
  assign to_uart = (write_type != WT_NONE) && (address == `UART_TX_ADDR);

  // ----------------------------------------------------------
  // busy / ready sequencing
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= S_IDLE;
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
      req_valid      <= 1'b0;
      tx_start       <= 1'b0;
    end else begin
      req_valid      <= 1'b0;  // all strobes are single cycle
      tx_start       <= 1'b0;
      data_out_ready <= 1'b0;
      case (state)
        S_IDLE: begin
          if (enable) begin
            busy <= 1'b1;
            if (to_uart) begin
              tx_start <= 1'b1;
              state    <= S_TX_LAUNCH;
            end else begin
              req_valid <= 1'b1;
              state     <= S_CACHE;
            end
          end
        end
        S_CACHE: begin
          if (cache_done) begin
            busy           <= 1'b0;
            data_out_ready <= (req_read_type != RT_NONE);  // stores give no pulse
            state          <= S_IDLE;
          end
        end
        S_TX_LAUNCH: state <= S_TX_WAIT;
        S_TX_WAIT: begin
          if (!tx_busy) begin  // stop bit finished
            busy  <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request registers and address split
  always_ff @(posedge clk) begin
    if (state == S_IDLE && enable) begin
      req_write_type <= write_type;
      req_read_type  <= read_type;
      req_offset     <= address[2:0];
      req_index      <= address[3 +: IX_W];
      req_tag        <= address[3 + IX_W +: TAG_W];
      req_data       <= data_in;
      tx_byte        <= data_in[7:0];
    end
    if (state == S_CACHE && cache_done && req_read_type != RT_NONE) begin
      data_out <= cache_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/ramio_pkg.sv
package ramio_pkg;

  // store width requested by the core
  typedef enum logic [1:0] {
    WT_NONE = 2'd0,
    WT_BYTE = 2'd1,
    WT_HALF = 2'd2,
    WT_WORD = 2'd3
  } write_type_e;

  // load width and extension
  typedef enum logic [2:0] {
    RT_NONE   = 3'd0,
    RT_BYTE   = 3'd1,  // sign extended
    RT_HALF   = 3'd2,  // sign extended
    RT_WORD   = 3'd3,
    RT_BYTE_U = 3'd4,  // zero extended
    RT_HALF_U = 3'd5   // zero extended
  } read_type_e;

  // burst RAM command strobe
  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } burst_cmd_e;

endpackage

//--- logic/ramio_defines.svh
`ifndef RAMIO_DEFINES_SVH
`define RAMIO_DEFINES_SVH

// ----------------------------------------------------------
// burst RAM geometry
// ----------------------------------------------------------
`define RAM_ADDRESS_BITWIDTH 8     // 256 lines of 8 bytes
`define BURST_READ_LATENCY 4       // read cmd to rd_data_valid

// ----------------------------------------------------------
// cache geometry
// ----------------------------------------------------------
`define CACHE_LINE_IX_BITWIDTH 4   // 16 lines

// ----------------------------------------------------------
// memory mapped UART
// ----------------------------------------------------------
`define UART_TX_ADDR 32'hFFFF_FFFF
`define CLKS_PER_BIT 10

`endif
